// File: hw/spm_apb_completer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spm_settings.svh"

// APB completer in front of the scratchpad RAM.
// Writes and errors finish in the first access cycle,
// reads add one wait state for the RAM latency.
module spm_apb_completer
(
   input wire logic clk_i,
   input wire logic rst_n_i,
   input wire spm_pkg::apb_req_t req_i,
   output spm_pkg::apb_rsp_t rsp_o,
   output logic mem_v_o,
   output logic mem_w_o,
   output logic [`SPM_WADDR_W-1:0] mem_addr_o,
   output logic [`SPM_DATA_W-1:0] mem_wdata_o,
   input wire logic [`SPM_DATA_W-1:0] mem_rdata_i
);

   localparam int IDX_W = `SPM_PADDR_W - 2; // Full word index width.
   localparam logic [IDX_W-1:0] ELS_IDX = IDX_W'(`SPM_ELS);

   spm_pkg::apb_state_e state_q;
   spm_pkg::apb_state_e state_d;

   logic [IDX_W-1:0] word_idx; // Byte address without the low bits.
   logic misaligned;
   logic out_of_range;
   logic decode_err;
   logic load_err; // Sample the decode this cycle.
   logic err_q; // Error flag of the transfer in flight.
   logic access; // Requester is in the access phase.
   logic in_setup;
   logic finish_now; // Write or error completes this cycle.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Address decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign word_idx = req_i.paddr[`SPM_PADDR_W-1:2];
   assign misaligned = |req_i.paddr[1:0]; // Word accesses only.
   assign out_of_range = word_idx >= ELS_IDX;
   assign decode_err = misaligned | out_of_range;

   // The setup cycle is seen from IDLE, or from DONE when the
   // requester starts the next transfer right away.
   assign load_err = (state_q == spm_pkg::IDLE) || (state_q == spm_pkg::DONE);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         err_q <= 1'b0;
      end
      else if (load_err)
      begin
         err_q <= decode_err;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Transfer FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign access = req_i.psel & req_i.penable;
   assign in_setup = (state_q == spm_pkg::SETUP);
   assign finish_now = in_setup & access & (err_q | req_i.pwrite);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         spm_pkg::IDLE:
         begin
            if (req_i.psel)
            begin
               state_d = spm_pkg::SETUP;
            end
         end
         spm_pkg::SETUP:
         begin
            if (access)
            begin
               // Reads wait one cycle for the RAM.
               if (err_q || req_i.pwrite)
               begin
                  state_d = spm_pkg::DONE;
               end
               else
               begin
                  state_d = spm_pkg::READ_WAIT;
               end
            end
         end
         spm_pkg::READ_WAIT:
         begin
            state_d = spm_pkg::DONE; // Data is on mem_rdata_i now.
         end
         spm_pkg::DONE:
         begin
            if (req_i.psel && !req_i.penable)
            begin
               state_d = spm_pkg::SETUP; // Back-to-back transfer.
            end
            else
            begin
               state_d = spm_pkg::IDLE;
            end
         end
         default:
         begin
            state_d = spm_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= spm_pkg::IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // RAM command and APB response
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // One RAM access per valid transfer, in its first access cycle.
   assign mem_v_o = in_setup & access & ~err_q;
   assign mem_w_o = req_i.pwrite;
   assign mem_addr_o = word_idx[`SPM_WADDR_W-1:0];
   assign mem_wdata_o = req_i.pwdata;

   assign rsp_o.pready = finish_now | (state_q == spm_pkg::READ_WAIT);
   assign rsp_o.pslverr = in_setup & access & err_q;
   assign rsp_o.prdata = mem_rdata_i; // Held by the RAM latch.

endmodule

`default_nettype wire

// File: hw/spm_mem_1rw_sync.sv
`timescale 1ns/1ps
`default_nettype none

// Single port RAM. One read or one write per clock.
// A read returns its word in the following cycle.
module spm_mem_1rw_sync
#(
   parameter int WIDTH = 32,
   parameter int ELS = 64,
   parameter bit LATCH_LAST_READ = 1'b1
)
(
   input wire logic clk_i,
   input wire logic rst_n_i,
   input wire logic v_i,
   input wire logic w_i,
   input wire logic [$clog2(ELS)-1:0] addr_i,
   input wire logic [WIDTH-1:0] data_i,
   output logic [WIDTH-1:0] data_o
);

   localparam int ADDR_W = $clog2(ELS);

   logic [WIDTH-1:0] mem [ELS];
   logic [ADDR_W-1:0] addr_q; // Address of the last read.
   logic [WIDTH-1:0] array_out;
   logic read_en;

   assign read_en = v_i & ~w_i;
   assign array_out = mem[addr_q]; // Array read port.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Array and read address
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_i)
   begin
      if (v_i && w_i)
      begin
         mem[addr_i] <= data_i; // Full word write.
      end
   end

   // The read address only moves on a read, so the array
   // output stays on the last word read.
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         addr_q <= '0;
      end
      else if (read_en)
      begin
         addr_q <= addr_i;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Output stage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   if (LATCH_LAST_READ)
   begin : g_llr
      logic read_en_q; // A read was issued last cycle.
      logic [WIDTH-1:0] last_q; // Word from the previous read.

      always_ff @(posedge clk_i or negedge rst_n_i)
      begin
         if (!rst_n_i)
         begin
            read_en_q <= 1'b0;
            last_q <= '0;
         end
         else
         begin
            read_en_q <= read_en;
            if (read_en_q)
            begin
               last_q <= array_out; // Capture the fresh word.
            end
         end
      end

      // Bypass in the cycle after a read, latched value otherwise.
      assign data_o = read_en_q ? array_out : last_q;
   end
   else
   begin : g_no_llr
      assign data_o = array_out; // Follows writes to addr_q too.
   end

endmodule

`default_nettype wire

// File: hw/spm_pkg.sv
`default_nettype none

package spm_pkg;

`include "spm_settings.svh"

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // APB bundles
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Requester to completer, 47 bits.
   typedef struct packed
   {
      logic psel; // Completer selected.
      logic penable; // Access phase.
      logic pwrite; // 1 for write, 0 for read.
      logic [`SPM_PADDR_W-1:0] paddr; // Byte address.
      logic [`SPM_DATA_W-1:0] pwdata; // Write data.
   } apb_req_t;

   // Completer to requester, 34 bits.
   typedef struct packed
   {
      logic pready; // Transfer completes.
      logic pslverr; // Error, valid with pready.
      logic [`SPM_DATA_W-1:0] prdata; // Read data, valid with pready.
   } apb_rsp_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Completer FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [1:0]
   {
      IDLE = 2'd0, // No transfer.
      SETUP = 2'd1, // Decoded, first access cycle.
      READ_WAIT = 2'd2, // RAM read in flight.
      DONE = 2'd3 // Handshake closed.
   } apb_state_e;

endpackage

`default_nettype wire

// File: hw/spm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spm_settings.svh"

// APB scratchpad. Completer in front of a single port RAM.
module spm_top
(
   input wire logic clk_i,
   input wire logic rst_n_i,
   input wire logic psel_i,
   input wire logic penable_i,
   input wire logic pwrite_i,
   input wire logic [`SPM_PADDR_W-1:0] paddr_i,
   input wire logic [`SPM_DATA_W-1:0] pwdata_i,
   output logic [`SPM_DATA_W-1:0] prdata_o,
   output logic pready_o,
   output logic pslverr_o
);

   spm_pkg::apb_req_t apb_req;
   spm_pkg::apb_rsp_t apb_rsp;

   logic mem_v;
   logic mem_w;
   logic [`SPM_WADDR_W-1:0] mem_addr;
   logic [`SPM_DATA_W-1:0] mem_wdata;
   logic [`SPM_DATA_W-1:0] mem_rdata;

   // Bus ports into the request bundle.
   assign apb_req.psel = psel_i;
   assign apb_req.penable = penable_i;
   assign apb_req.pwrite = pwrite_i;
   assign apb_req.paddr = paddr_i;
   assign apb_req.pwdata = pwdata_i;

   assign prdata_o = apb_rsp.prdata;
   assign pready_o = apb_rsp.pready;
   assign pslverr_o = apb_rsp.pslverr;

   spm_apb_completer u_completer
   (
      .clk_i (clk_i),
      .rst_n_i (rst_n_i),
      .req_i (apb_req),
      .rsp_o (apb_rsp),
      .mem_v_o (mem_v),
      .mem_w_o (mem_w),
      .mem_addr_o (mem_addr),
      .mem_wdata_o (mem_wdata),
      .mem_rdata_i (mem_rdata)
   );

   spm_mem_1rw_sync
   #(
      .WIDTH (`SPM_DATA_W),
      .ELS (`SPM_ELS),
      .LATCH_LAST_READ (`SPM_LATCH_LAST_READ)
   )
   u_mem
   (
      .clk_i (clk_i),
      .rst_n_i (rst_n_i),
      .v_i (mem_v),
      .w_i (mem_w),
      .addr_i (mem_addr),
      .data_i (mem_wdata),
      .data_o (mem_rdata)
   );

endmodule

`default_nettype wire

// File: include/spm_settings.svh
`ifndef SPM_SETTINGS_SVH
`define SPM_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratchpad geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SPM_DATA_W 32 // Word width in bits.
`define SPM_ELS 64 // Number of words.
`define SPM_WADDR_W 6 // Word index width, log2 of SPM_ELS.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Byte address, wider than the array so that
// out-of-range accesses can reach the completer.
`define SPM_PADDR_W 12

`define SPM_LATCH_LAST_READ 1 // Hold prdata between reads.

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scratchpad testbench with Verilator.
# The run counts as failed if the fail message shows up in the log.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing \
   --timescale 1ns/1ps \
   --top-module spm_tb \
   --Mdir "$OBJ_DIR" \
   -o Vspm_tb \
   -f sim.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ_DIR/Vspm_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
   echo "simulation ended without a result"
   exit 1
fi

exit 0

// File: sim.f
+incdir+include
hw/spm_pkg.sv
hw/spm_mem_1rw_sync.sv
hw/spm_apb_completer.sv
hw/spm_top.sv
verification/spm_tb.sv

// File: verification/spm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spm_settings.svh"

module spm_tb;

   localparam int DATA_W = `SPM_DATA_W;
   localparam int PADDR_W = `SPM_PADDR_W;
   localparam int ELS = `SPM_ELS;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_ERR = 32; // Error transfers, each followed by a read.
   localparam int NUM_HOLD = 24; // Rounds of the last-read hold test.
   localparam int NUM_MIX = 400;
   // A hold round is a read, a write, an error and idle gaps.
   localparam int NUM_XFERS = 2 * ELS + 2 * NUM_ERR + 4 * NUM_HOLD + NUM_MIX;
   localparam int TIMEOUT_CYCLES = NUM_XFERS * 4 + RESET_CYCLES + 100;

   logic clk;
   logic rst_n;
   logic psel;
   logic penable;
   logic pwrite;
   logic [PADDR_W-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic pready;
   logic pslverr;

   logic [DATA_W-1:0] model_mem [int]; // Words written so far.
   logic [DATA_W-1:0] last_read; // Word the RAM latch should show.
   bit last_known;
   integer seed;
   int cycle_count = 0;

   spm_top uut
   (
      .clk_i (clk),
      .rst_n_i (rst_n),
      .psel_i (psel),
      .penable_i (penable),
      .pwrite_i (pwrite),
      .paddr_i (paddr),
      .pwdata_i (pwdata),
      .prdata_o (prdata),
      .pready_o (pready),
      .pslverr_o (pslverr)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES)
      begin
         $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
         $display("sim failed");
         $fatal(1, "run aborted");
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks and decode rules
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      if (actual !== expected)
      begin
         $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic bit addr_invalid(input logic [PADDR_W-1:0] addr);
      return (addr[1:0] != 2'b00) || (int'(addr[PADDR_W-1:2]) >= ELS);
   endfunction

   // Word the RAM would see for this byte address.
   function automatic int alias_index(input logic [PADDR_W-1:0] addr);
      return int'(addr[PADDR_W-1:2]) % ELS;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Random stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic rand_below(input int limit, output int value);
      value = {$random(seed)} % limit;
   endtask

   task automatic rand_word(output logic [DATA_W-1:0] data);
      data = $random(seed);
   endtask

   task automatic good_addr(output logic [PADDR_W-1:0] addr);
      int idx;
      rand_below(ELS, idx);
      addr = PADDR_W'(idx * 4);
   endtask

   task automatic bad_addr(output logic [PADDR_W-1:0] addr);
      int kind;
      int idx;
      int low;
      rand_below(2, kind);
      rand_below(3, low);
      if (kind == 0)
      begin
         rand_below(ELS, idx);
         addr = PADDR_W'(idx * 4 + low + 1); // Misaligned.
      end
      else
      begin
         rand_below((1 << (PADDR_W - 2)) - ELS, idx);
         addr = PADDR_W'((idx + ELS) * 4); // Past the last word.
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // APB requester
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Cycles are counted from the setup cycle to the pready cycle.
   task automatic apb_transfer(input logic wr, input logic [PADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err,
                               output int cycles);
      @(posedge clk);
      psel <= 1'b1; // Setup phase.
      penable <= 1'b0;
      pwrite <= wr;
      paddr <= addr;
      pwdata <= wdata;
      cycles = 1;
      @(negedge clk);
      while (pready !== 1'b1)
      begin
         @(posedge clk);
         penable <= 1'b1; // Access phase.
         cycles = cycles + 1;
         @(negedge clk);
      end
      rdata = prdata;
      err = pslverr;
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_word(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      logic [DATA_W-1:0] rdata;
      logic err;
      int cycles;
      bit bad;
      bad = addr_invalid(addr);
      apb_transfer(1'b1, addr, data, rdata, err, cycles);
      check_value("pslverr_o", DATA_W'(bad), DATA_W'(err));
      check_value("completion cycles", DATA_W'(2), DATA_W'(cycles));
      if (last_known)
      begin
         check_value("prdata_o", last_read, rdata); // Latch holds over writes.
      end
      if (!bad)
      begin
         model_mem[alias_index(addr)] = data;
      end
   endtask

   task automatic read_word(input logic [PADDR_W-1:0] addr);
      logic [DATA_W-1:0] rdata;
      logic err;
      int cycles;
      int idx;
      bit bad;
      bad = addr_invalid(addr);
      idx = alias_index(addr);
      apb_transfer(1'b0, addr, DATA_W'(0), rdata, err, cycles);
      check_value("pslverr_o", DATA_W'(bad), DATA_W'(err));
      if (bad)
      begin
         check_value("completion cycles", DATA_W'(2), DATA_W'(cycles));
         if (last_known)
         begin
            check_value("prdata_o", last_read, rdata);
         end
      end
      else
      begin
         check_value("completion cycles", DATA_W'(3), DATA_W'(cycles));
         if (model_mem.exists(idx))
         begin
            check_value("prdata_o", model_mem[idx], rdata);
            last_read = model_mem[idx];
            last_known = 1'b1;
         end
         else
         begin
            last_known = 1'b0; // Contents not reset.
         end
      end
   endtask

   task automatic idle_hold(input int n);
      repeat (n)
      begin
         @(negedge clk);
         if (last_known)
         begin
            check_value("prdata_o", last_read, prdata);
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin : stimulus
      int order [ELS];
      int tmp;
      int j;
      int kind;
      logic [PADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;

      seed = 82;
      rst_n <= 1'b0;
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= '0;
      pwdata <= '0;
      last_read = '0; // Latch resets to zero.
      last_known = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("pready_o", DATA_W'(0), DATA_W'(pready));
      check_value("pslverr_o", DATA_W'(0), DATA_W'(pslverr));
      check_value("prdata_o", last_read, prdata);

      // Fill every word, then read back in shuffled order.
      for (int i = 0; i < ELS; i++)
      begin
         rand_word(data);
         write_word(PADDR_W'(i * 4), data);
      end
      for (int i = 0; i < ELS; i++)
      begin
         order[i] = i;
      end
      for (int i = ELS - 1; i > 0; i--)
      begin
         rand_below(i + 1, j);
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < ELS; i++)
      begin
         read_word(PADDR_W'(order[i] * 4));
      end

      // Bad addresses must leave the aliased word alone.
      repeat (NUM_ERR)
      begin
         bad_addr(addr);
         rand_word(data);
         rand_below(2, kind);
         if (kind == 0)
         begin
            write_word(addr, data);
         end
         else
         begin
            read_word(addr);
         end
         read_word(PADDR_W'(alias_index(addr) * 4));
      end

      repeat (NUM_HOLD)
      begin
         good_addr(addr);
         read_word(addr);
         idle_hold(2);
         rand_word(data);
         write_word(addr, data); // Overwrite the word just read.
         idle_hold(2);
         bad_addr(addr);
         rand_word(data);
         write_word(addr, data);
         idle_hold(2);
      end

      repeat (NUM_MIX)
      begin
         rand_below(8, kind);
         if (kind == 0)
         begin
            bad_addr(addr); // About one in eight.
         end
         else
         begin
            good_addr(addr);
         end
         rand_below(2, kind);
         rand_word(data);
         if (kind == 1)
         begin
            write_word(addr, data);
         end
         else
         begin
            read_word(addr);
         end
      end

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire
